//--- verilog/cdw_pkg.sv
`default_nettype none

package cdw_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int unsigned PLEN    = 56;
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned DID_W   = 24;
    localparam int unsigned CAUSE_W = 12;
    localparam int unsigned DW_W    = 64;

    // Device context is four doublewords in base format
    localparam int unsigned DC_BEATS  = 4;
    localparam int unsigned DC_BEAT_W = 2;

    // --------------------
    // Fault causes
    // --------------------
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_INVALID   = 12'd258;
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_MISCONFIG = 12'd259;
    localparam logic [CAUSE_W-1:0] CAUSE_DDT_CORRUPT   = 12'd268;

    // ddtp.MODE values that select a walk depth
    // Off and bare never walk
    localparam logic [3:0] MODE_1LVL = 4'd2;
    localparam logic [3:0] MODE_2LVL = 4'd3;
    localparam logic [3:0] MODE_3LVL = 4'd4;

    // iohgatp.MODE values we accept
    localparam logic [3:0] HG_BARE   = 4'd0;
    localparam logic [3:0] HG_SV39X4 = 4'd8;
    localparam logic [3:0] HG_SV48X4 = 4'd9;
    localparam logic [3:0] HG_SV57X4 = 4'd10;

    // --------------------
    // Table entry layouts
    // --------------------
    // Non-leaf DDT entry
    typedef struct packed {
        logic [9:0]       reserved_hi;
        logic [PPN_W-1:0] ppn;
        logic [8:0]       reserved_lo;
        logic             v;
    } nl_entry_t;

    // DC doubleword 0, translation control
    typedef struct packed {
        logic [59:0] reserved;
        logic        sbe;
        logic        t2gpa;
        logic        en_ats;
        logic        v;
    } dc_tc_t;

    // DC doubleword 1, second-stage root
    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      gscid;
        logic [PPN_W-1:0] ppn;
    } dc_iohgatp_t;

    // DC doubleword 2, only the low reserved field is checked
    typedef struct packed {
        logic [51:0] other;
        logic [11:0] reserved;
    } dc_ta_t;

    // DC doubleword 3, first-stage context
    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      reserved;
        logic [PPN_W-1:0] ppn;
    } dc_fsc_t;

    typedef struct packed {
        dc_tc_t      tc;
        dc_iohgatp_t iohgatp;
        dc_ta_t      ta;
        dc_fsc_t     fsc;
    } dc_t;

    // Capability and feature-control bits used by the checks
    typedef struct packed {
        logic sv39x4;
        logic sv48x4;
        logic sv57x4;
        logic fctl_be;
    } caps_t;

    // --------------------
    // Ports
    // --------------------
    typedef struct packed {
        logic            ar_valid;
        logic [PLEN-1:0] ar_addr;
        logic [1:0]      ar_len;
        logic            r_ready;
    } mem_req_t;

    typedef struct packed {
        logic            ar_ready;
        logic            r_valid;
        logic [DW_W-1:0] r_data;
        logic            r_last;
        logic            r_err;
    } mem_resp_t;

    typedef struct packed {
        logic [DID_W-1:0] did;
        dc_t              dc;
    } cdw_update_t;

endpackage

`default_nettype wire

//--- verilog/ddt_walk_ptr.sv
`default_nettype none

module ddt_walk_ptr (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       start_i,
    input  wire logic                       step_i,
    input  wire logic [cdw_pkg::DID_W-1:0]  did_i,
    input  wire logic [cdw_pkg::PPN_W-1:0]  ddtp_ppn_i,
    input  wire logic [3:0]                 ddtp_mode_i,
    input  wire logic [cdw_pkg::PPN_W-1:0]  nl_ppn_i,
    output logic      [cdw_pkg::PLEN-1:0]   pptr_o,
    output logic                            last_lvl_o,
    output logic      [cdw_pkg::DID_W-1:0]  did_o
);

    // Levels count down 3, 2, 1 and level one holds the device context
    logic [1:0]                lvl_q, lvl_n;
    logic [cdw_pkg::DID_W-1:0] did_q, did_sel;
    logic [cdw_pkg::PPN_W-1:0] base_ppn;
    logic [11:0]               offset;

    always_comb begin
        // Start takes the fresh request, step reuses the latched one
        did_sel  = start_i ? did_i : did_q;
        base_ppn = start_i ? ddtp_ppn_i : nl_ppn_i;
        if (start_i) begin
            case (ddtp_mode_i)
                cdw_pkg::MODE_3LVL: lvl_n = 2'd3;
                cdw_pkg::MODE_2LVL: lvl_n = 2'd2;
                default:            lvl_n = 2'd1;
            endcase
        end else begin
            lvl_n = lvl_q - 2'd1;
        end
        // Device ID slice for the level about to be read
        case (lvl_n)
            2'd3:    offset = {1'b0, did_sel[23:16], 3'b000};
            2'd2:    offset = {did_sel[15:7], 3'b000};
            default: offset = {did_sel[6:0], 5'b00000};
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q  <= 2'd1;
            did_q  <= '0;
            pptr_o <= '0;
        end else if (start_i || step_i) begin
            lvl_q  <= lvl_n;
            did_q  <= did_sel;
            pptr_o <= {base_ppn, offset};
        end
    end

    assign last_lvl_o = (lvl_q == 2'd1);
    assign did_o      = did_q;

endmodule

`default_nettype wire

//--- verilog/dc_assembler.sv
`default_nettype none

module dc_assembler (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire logic                          clear_i,
    input  wire logic                          capture_i,
    input  wire logic [cdw_pkg::DW_W-1:0]      beat_data_i,
    output logic      [cdw_pkg::DC_BEAT_W-1:0] beat_idx_o,
    output cdw_pkg::dc_t                       dc_o
);

    logic [cdw_pkg::DC_BEAT_W-1:0] beat_q;
    cdw_pkg::dc_t                  dc_q;

    // Beat counter, wraps after the fourth doubleword
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
        end else if (clear_i) begin
            beat_q <= '0;
        end else if (capture_i) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // Context store, the beat index picks the field
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            case (beat_q)
                2'd0:    dc_q.tc      <= cdw_pkg::dc_tc_t'(beat_data_i);
                2'd1:    dc_q.iohgatp <= cdw_pkg::dc_iohgatp_t'(beat_data_i);
                2'd2:    dc_q.ta      <= cdw_pkg::dc_ta_t'(beat_data_i);
                default: dc_q.fsc     <= cdw_pkg::dc_fsc_t'(beat_data_i);
            endcase
        end
    end

    assign beat_idx_o = beat_q;
    // Also feeds tc back to the checker for the iohgatp beat
    assign dc_o       = dc_q;

endmodule

`default_nettype wire

//--- verilog/ddt_entry_check.sv
`default_nettype none

module ddt_entry_check (
    input  wire logic [cdw_pkg::DW_W-1:0]      data_i,
    input  wire logic                          leaf_i,
    input  wire logic [cdw_pkg::DC_BEAT_W-1:0] beat_idx_i,
    input  wire cdw_pkg::dc_tc_t               tc_i,
    input  wire cdw_pkg::caps_t                caps_i,
    output logic                               fault_o,
    output logic      [cdw_pkg::CAUSE_W-1:0]   cause_o
);

    // Views of the read data, one per layout
    cdw_pkg::nl_entry_t   nl;
    cdw_pkg::dc_tc_t      tc;
    cdw_pkg::dc_iohgatp_t hg;
    cdw_pkg::dc_ta_t      ta;
    cdw_pkg::dc_fsc_t     fsc;

    logic invalid;
    logic misconfig;
    logic hg_mode_ok;
    logic hg_cap_ok;

    assign nl  = cdw_pkg::nl_entry_t'(data_i);
    assign tc  = cdw_pkg::dc_tc_t'(data_i);
    assign hg  = cdw_pkg::dc_iohgatp_t'(data_i);
    assign ta  = cdw_pkg::dc_ta_t'(data_i);
    assign fsc = cdw_pkg::dc_fsc_t'(data_i);

    // --------------------
    // iohgatp mode support
    // --------------------
    assign hg_mode_ok = (hg.mode == cdw_pkg::HG_BARE)   || (hg.mode == cdw_pkg::HG_SV39X4) ||
                        (hg.mode == cdw_pkg::HG_SV48X4) || (hg.mode == cdw_pkg::HG_SV57X4);

    // GXL is zero, so only the x4 capabilities matter
    assign hg_cap_ok = !((hg.mode == cdw_pkg::HG_SV39X4) && !caps_i.sv39x4) &&
                       !((hg.mode == cdw_pkg::HG_SV48X4) && !caps_i.sv48x4) &&
                       !((hg.mode == cdw_pkg::HG_SV57X4) && !caps_i.sv57x4);

    always_comb begin
        invalid   = 1'b0;
        misconfig = 1'b0;
        if (!leaf_i) begin
            // Non-leaf DDT entry
            invalid   = !nl.v;
            misconfig = (|nl.reserved_hi) || (|nl.reserved_lo);
        end else begin
            case (beat_idx_i)
                2'd0: begin
                    invalid   = !tc.v;
                    misconfig = (|tc.reserved) || (tc.t2gpa && !tc.en_ats) ||
                                (tc.sbe != caps_i.fctl_be);
                end
                2'd1: begin
                    // tc was stored on the previous beat
                    misconfig = !hg_mode_ok || !hg_cap_ok ||
                                ((hg.mode == cdw_pkg::HG_BARE) && tc_i.t2gpa);
                end
                2'd2:    misconfig = |ta.reserved;
                default: misconfig = |fsc.reserved;
            endcase
        end
    end

    // Not-valid wins over misconfigured, as V is checked first
    assign fault_o = invalid || misconfig;
    assign cause_o = invalid ? cdw_pkg::CAUSE_DDT_INVALID : cdw_pkg::CAUSE_DDT_MISCONFIG;

endmodule

`default_nettype wire

//--- verilog/cdw_ctrl.sv
`default_nettype none

module cdw_ctrl (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire logic                          ddtc_access_i,
    input  wire logic                          ddtc_hit_i,
    input  wire logic [3:0]                    ddtp_mode_i,
    input  wire cdw_pkg::mem_resp_t            mem_resp_i,
    input  wire logic                          fault_i,
    input  wire logic [cdw_pkg::CAUSE_W-1:0]   cause_i,
    input  wire logic                          last_lvl_i,
    input  wire logic [cdw_pkg::DC_BEAT_W-1:0] beat_idx_i,
    output logic                               start_o,
    output logic                               step_o,
    output logic                               clear_o,
    output logic                               capture_o,
    output logic                               leaf_o,
    output logic                               ar_valid_o,
    output logic      [1:0]                    ar_len_o,
    output logic                               r_ready_o,
    output logic                               cdw_active_o,
    output logic                               cdw_error_o,
    output logic      [cdw_pkg::CAUSE_W-1:0]   cause_o,
    output logic                               update_valid_o
);

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        NON_LEAF,
        LEAF,
        DRAIN,
        ERROR
    } state_t;

    state_t                       state_q, state_n;
    logic [cdw_pkg::CAUSE_W-1:0]  cause_q, cause_n;
    logic                         update_q, update_n;
    logic                         walk_mode;
    logic                         beat_ok;
    logic                         last_beat;

    assign walk_mode = (ddtp_mode_i == cdw_pkg::MODE_1LVL) ||
                       (ddtp_mode_i == cdw_pkg::MODE_2LVL) ||
                       (ddtp_mode_i == cdw_pkg::MODE_3LVL);

    // Accepted beat, and whether it closes the device context
    assign beat_ok   = mem_resp_i.r_valid && r_ready_o;
    assign last_beat = (beat_idx_i == cdw_pkg::DC_BEAT_W'(cdw_pkg::DC_BEATS - 1));

    // Read length: one beat for a directory entry, a full DC at the leaf
    assign ar_len_o = last_lvl_i ? 2'(cdw_pkg::DC_BEATS - 1) : 2'd0;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_n    = state_q;
        cause_n    = cause_q;
        update_n   = 1'b0;
        start_o    = 1'b0;
        step_o     = 1'b0;
        capture_o  = 1'b0;
        ar_valid_o = 1'b0;
        r_ready_o  = 1'b0;

        case (state_q)
            IDLE: begin
                // DDTC miss in a walking mode
                if (ddtc_access_i && !ddtc_hit_i && walk_mode) begin
                    start_o = 1'b1;
                    state_n = ADDR;
                end
            end
            ADDR: begin
                // Held until the memory takes the address
                ar_valid_o = 1'b1;
                if (mem_resp_i.ar_ready) begin
                    state_n = last_lvl_i ? LEAF : NON_LEAF;
                end
            end
            NON_LEAF: begin
                r_ready_o = 1'b1;
                if (mem_resp_i.r_valid) begin
                    if (mem_resp_i.r_err) begin
                        cause_n = cdw_pkg::CAUSE_DDT_CORRUPT;
                        state_n = ERROR;
                    end else if (fault_i) begin
                        cause_n = cause_i;
                        state_n = ERROR;
                    end else begin
                        // Pointer moves down one level, then read again
                        step_o  = 1'b1;
                        state_n = ADDR;
                    end
                end
            end
            LEAF: begin
                r_ready_o = 1'b1;
                if (beat_ok) begin
                    capture_o = 1'b1;
                    if (mem_resp_i.r_err || fault_i) begin
                        cause_n = mem_resp_i.r_err ? cdw_pkg::CAUSE_DDT_CORRUPT : cause_i;
                        // Rest of the burst must be consumed first
                        state_n = last_beat ? ERROR : DRAIN;
                    end else if (last_beat) begin
                        update_n = 1'b1;
                        state_n  = IDLE;
                    end
                end
            end
            DRAIN: begin
                r_ready_o = 1'b1;
                if (mem_resp_i.r_valid && mem_resp_i.r_last) begin
                    state_n = ERROR;
                end
            end
            ERROR: begin
                // One-cycle error pulse
                state_n = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            cause_q  <= '0;
            update_q <= 1'b0;
        end else begin
            state_q  <= state_n;
            cause_q  <= cause_n;
            update_q <= update_n;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    assign clear_o        = start_o;
    assign leaf_o         = (state_q == LEAF);
    // Drops when the closing update or error pulse appears
    assign cdw_active_o   = (state_q != IDLE) && (state_q != ERROR);
    assign cdw_error_o    = (state_q == ERROR);
    assign cause_o        = cause_q;
    assign update_valid_o = update_q;

endmodule

`default_nettype wire

//--- verilog/iommu_cdw.sv
`default_nettype none

module iommu_cdw (
    input  wire logic                        clk_i,
    input  wire logic                        rst_ni,
    input  wire logic                        ddtc_access_i,
    input  wire logic                        ddtc_hit_i,
    input  wire logic [cdw_pkg::DID_W-1:0]   req_did_i,
    input  wire logic [cdw_pkg::PPN_W-1:0]   ddtp_ppn_i,
    input  wire logic [3:0]                  ddtp_mode_i,
    input  wire cdw_pkg::caps_t              caps_i,
    input  wire cdw_pkg::mem_resp_t          mem_resp_i,
    output cdw_pkg::mem_req_t                mem_req_o,
    output logic                             cdw_active_o,
    output logic                             cdw_error_o,
    output logic      [cdw_pkg::CAUSE_W-1:0] cause_code_o,
    output logic                             update_valid_o,
    output cdw_pkg::cdw_update_t             update_o
);

    logic                          start, step, clear, capture, leaf;
    logic                          fault, last_lvl;
    logic [cdw_pkg::CAUSE_W-1:0]   chk_cause;
    logic [cdw_pkg::DC_BEAT_W-1:0] beat_idx;
    logic [cdw_pkg::PLEN-1:0]      pptr;
    logic [cdw_pkg::DID_W-1:0]     did;
    cdw_pkg::dc_t                  dc;
    cdw_pkg::nl_entry_t            nl;

    // Read data seen as a directory entry for the next pointer
    assign nl = cdw_pkg::nl_entry_t'(mem_resp_i.r_data);

    cdw_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ddtc_access_i  (ddtc_access_i),
        .ddtc_hit_i     (ddtc_hit_i),
        .ddtp_mode_i    (ddtp_mode_i),
        .mem_resp_i     (mem_resp_i),
        .fault_i        (fault),
        .cause_i        (chk_cause),
        .last_lvl_i     (last_lvl),
        .beat_idx_i     (beat_idx),
        .start_o        (start),
        .step_o         (step),
        .clear_o        (clear),
        .capture_o      (capture),
        .leaf_o         (leaf),
        .ar_valid_o     (mem_req_o.ar_valid),
        .ar_len_o       (mem_req_o.ar_len),
        .r_ready_o      (mem_req_o.r_ready),
        .cdw_active_o   (cdw_active_o),
        .cdw_error_o    (cdw_error_o),
        .cause_o        (cause_code_o),
        .update_valid_o (update_valid_o)
    );

    ddt_walk_ptr u_ptr (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .step_i      (step),
        .did_i       (req_did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .nl_ppn_i    (nl.ppn),
        .pptr_o      (pptr),
        .last_lvl_o  (last_lvl),
        .did_o       (did)
    );

    dc_assembler u_asm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear),
        .capture_i   (capture),
        .beat_data_i (mem_resp_i.r_data),
        .beat_idx_o  (beat_idx),
        .dc_o        (dc)
    );

    ddt_entry_check u_chk (
        .data_i     (mem_resp_i.r_data),
        .leaf_i     (leaf),
        .beat_idx_i (beat_idx),
        .tc_i       (dc.tc),
        .caps_i     (caps_i),
        .fault_o    (fault),
        .cause_o    (chk_cause)
    );

    assign mem_req_o.ar_addr = pptr;
    assign update_o.did      = did;
    assign update_o.dc       = dc;

endmodule

`default_nettype wire

//--- tb/cdw_monitor.sv
`default_nettype none

module cdw_monitor (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  update_valid_i,
    input  wire cdw_pkg::cdw_update_t  update_i,
    input  wire logic                  cdw_error_i,
    input  wire logic [11:0]           cause_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Expected results, queued by the stimulus
    logic                 exp_err_q [$];
    logic [11:0]          exp_cause_q [$];
    cdw_pkg::cdw_update_t exp_upd_q [$];
    int                   err_cnt = 0;
    int                   seen_cnt = 0;

    task automatic push_expect(input logic is_err, input logic [11:0] c,
                               input cdw_pkg::cdw_update_t u);
        exp_err_q.push_back(is_err);
        exp_cause_q.push_back(c);
        exp_upd_q.push_back(u);
    endtask

    always @(posedge clk_i) begin
        if (rst_ni && (update_valid_i || cdw_error_i)) begin
            seen_cnt++;
            if (exp_err_q.size() == 0) begin
                $display("Walk result at %0t ns with nothing expected", $time);
                err_cnt++;
            end else if (update_valid_i && cdw_error_i) begin
                $display("Fail at %0t ns: update and error in one cycle", $time);
                err_cnt++;
            end else if (exp_err_q[0] != cdw_error_i) begin
                $display("Fail at %0t ns: got %s, expected %s", $time,
                         cdw_error_i ? "error" : "update",
                         exp_err_q[0] ? "error" : "update");
                err_cnt++;
            end else if (cdw_error_i && cause_i != exp_cause_q[0]) begin
                $display("Fail at %0t ns: cause %0d, expected %0d", $time, cause_i,
                         exp_cause_q[0]);
                err_cnt++;
            end else if (update_valid_i && update_i != exp_upd_q[0]) begin
                $display("Fail at %0t ns: update %h, expected %h", $time, update_i,
                         exp_upd_q[0]);
                err_cnt++;
            end
            if (exp_err_q.size() != 0) begin
                void'(exp_err_q.pop_front());
                void'(exp_cause_q.pop_front());
                void'(exp_upd_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_iommu_cdw.sv
`default_nettype none

module tb_iommu_cdw;
    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  ddtc_access;
    logic                  ddtc_hit;
    logic [23:0]           req_did;
    logic [43:0]           ddtp_ppn;
    logic [3:0]            ddtp_mode;
    cdw_pkg::caps_t        caps;
    cdw_pkg::mem_resp_t    mem_resp = '0;
    cdw_pkg::mem_req_t     mem_req;
    logic                  active;
    logic                  walk_err;
    logic [11:0]           cause;
    logic                  upd_valid;
    cdw_pkg::cdw_update_t  upd;

    // Sparse memory image and the expected read addresses of one walk
    logic [63:0] mem [logic [55:0]];
    logic [55:0] exp_addr_q [$];
    logic [55:0] ar_hold_addr;
    bit          busy;
    bit          ar_hold;
    bit          err_en;
    int          burst_beat;
    int          walk_beats;
    int          err_beat;
    int          addr_errs;
    int          timeouts;
    // Expected outcome of the current walk
    logic                 exp_is_err;
    logic [11:0]          exp_cause;
    cdw_pkg::cdw_update_t exp_upd;

    always #2 clk_i = ~clk_i;

    iommu_cdw UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ddtc_access_i  (ddtc_access),
        .ddtc_hit_i     (ddtc_hit),
        .req_did_i      (req_did),
        .ddtp_ppn_i     (ddtp_ppn),
        .ddtp_mode_i    (ddtp_mode),
        .caps_i         (caps),
        .mem_resp_i     (mem_resp),
        .mem_req_o      (mem_req),
        .cdw_active_o   (active),
        .cdw_error_o    (walk_err),
        .cause_code_o   (cause),
        .update_valid_o (upd_valid),
        .update_o       (upd)
    );

    cdw_monitor u_mon (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .update_valid_i (upd_valid),
        .update_i       (upd),
        .cdw_error_i    (walk_err),
        .cause_i        (cause)
    );

    // Unwritten locations return a pattern built from the full address
    function automatic logic [63:0] mem_rd(input logic [55:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {8'ha5, a} ^ {a[7:0], 56'h0};
    endfunction

    // Byte offset of a table entry within its page, per level
    function automatic logic [11:0] dw_offset(input logic [23:0] did, input int lvl);
        if (lvl == 3) begin
            return {1'b0, did[23:16], 3'b000};
        end else if (lvl == 2) begin
            return {did[15:7], 3'b000};
        end
        return {did[6:0], 5'b00000};
    endfunction

    // --------------------
    // Reference walk over the memory image
    // --------------------
    function automatic void ref_walk(input logic [23:0] did, input int mode,
                                     input logic [43:0] root, input cdw_pkg::caps_t cp);
        int           lvl;
        int           k;
        logic [43:0]  ppn;
        logic [55:0]  a;
        logic [63:0]  d;
        logic [63:0]  tc;
        logic [255:0] dcv;
        logic [3:0]   hg;
        logic [11:0]  c;
        lvl = mode - 1;
        k = 0;
        ppn = root;
        tc = '0;
        dcv = '0;
        exp_is_err = 1'b0;
        exp_cause = '0;
        exp_addr_q.delete();
        while (lvl > 1) begin
            a = {ppn, dw_offset(did, lvl)};
            exp_addr_q.push_back(a);
            d = mem_rd(a);
            c = '0;
            if (err_en && err_beat == k) c = 12'd268;
            else if (!d[0]) c = 12'd258;
            else if ((|d[9:1]) || (|d[63:54])) c = 12'd259;
            if (c != 0) begin
                exp_is_err = 1'b1;
                exp_cause = c;
                return;
            end
            ppn = d[53:10];
            lvl--;
            k++;
        end
        a = {ppn, dw_offset(did, 1)};
        exp_addr_q.push_back(a);
        // Leaf burst, first fault wins and later beats only drain
        for (int b = 0; b < 4; b++) begin
            d = mem_rd(a + 56'(8 * b));
            dcv[255 - 64 * b -: 64] = d;
            if (b == 0) tc = d;
            c = '0;
            hg = d[63:60];
            if (err_en && err_beat == k + b) begin
                c = 12'd268;
            end else if (b == 0) begin
                if (!d[0]) c = 12'd258;
                else if ((|d[63:4]) || (d[2] && !d[1]) || (d[3] != cp.fctl_be)) c = 12'd259;
            end else if (b == 1) begin
                if (!((hg == 0) || (hg == 8 && cp.sv39x4) || (hg == 9 && cp.sv48x4) ||
                      (hg == 10 && cp.sv57x4)) || (hg == 0 && tc[2])) c = 12'd259;
            end else if (b == 2) begin
                if (|d[11:0]) c = 12'd259;
            end else if (|d[59:44]) begin
                c = 12'd259;
            end
            if (c != 0 && !exp_is_err) begin
                exp_is_err = 1'b1;
                exp_cause = c;
            end
        end
        exp_upd.did = did;
        exp_upd.dc  = cdw_pkg::dc_t'(dcv);
    endfunction

    // --------------------
    // Memory model
    // --------------------
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            mem_resp <= '0;
            busy = 1'b0;
            ar_hold = 1'b0;
        end else begin
            // A stalled address must stay put
            if (ar_hold && (!mem_req.ar_valid || mem_req.ar_addr != ar_hold_addr)) begin
                $display("Fail at %0t ns: address changed while stalled", $time);
                addr_errs++;
            end
            if (mem_resp.r_valid && mem_req.r_ready) begin
                walk_beats++;
                burst_beat++;
                if (mem_resp.r_last) busy = 1'b0;
            end
            if (busy && mem_req.ar_valid) begin
                $display("Fail at %0t ns: address phase before r_last", $time);
                addr_errs++;
            end else if (mem_req.ar_valid && mem_resp.ar_ready) begin
                if (exp_addr_q.size() == 0 || exp_addr_q[0] != mem_req.ar_addr) begin
                    $display("Fail at %0t ns: read address %h not expected", $time,
                             mem_req.ar_addr);
                    addr_errs++;
                end
                if (exp_addr_q.size() != 0) void'(exp_addr_q.pop_front());
                busy = 1'b1;
                burst_beat = 0;
            end
            ar_hold = mem_req.ar_valid && !mem_resp.ar_ready;
            ar_hold_addr = mem_req.ar_addr;
            mem_resp.ar_ready <= !busy && ($urandom % 3 != 0);
            // A presented beat holds until taken
            if (mem_resp.r_valid && !mem_req.r_ready && busy) begin
                mem_resp.r_valid <= 1'b1;
            end else if (busy && ($urandom % 3 != 0)) begin
                mem_resp.r_valid <= 1'b1;
                mem_resp.r_data  <= mem_rd(mem_req.ar_addr + 56'(8 * burst_beat));
                mem_resp.r_last  <= (burst_beat == int'(mem_req.ar_len));
                mem_resp.r_err   <= err_en && (walk_beats == err_beat);
            end else begin
                mem_resp.r_valid <= 1'b0;
            end
        end
    end

    // Builds one walk image, runs it and waits for the result
    task automatic run_case(input int mode, input int kind);
        logic [23:0]    did;
        logic [43:0]    root;
        logic [43:0]    ppn;
        logic [43:0]    nxt;
        logic [55:0]    a;
        logic [63:0]    dw [4];
        cdw_pkg::caps_t cp;
        int             lvl;
        int             n0;
        int             t;
        bit             act_bad;
        did = $urandom;
        root = {12'($urandom), 32'($urandom)};
        ppn = root;
        cp = 4'b1110;
        lvl = mode - 1;
        if (lvl == 1 && (kind == 1 || kind == 2)) kind = 3;
        while (lvl > 1) begin
            a = {ppn, dw_offset(did, lvl)};
            nxt = {12'($urandom), 32'($urandom)};
            mem[a] = {10'h0, nxt, 9'h0, 1'b1};
            if (lvl == mode - 1 && kind == 1) mem[a][0] = 1'b0;
            if (lvl == mode - 1 && kind == 2) mem[a][60] = 1'b1;
            ppn = nxt;
            lvl--;
        end
        dw[0] = 64'h3;
        dw[1] = {32'($urandom), 32'($urandom)};
        dw[1][63:60] = ($urandom % 4 == 0) ? 4'd0 : 4'(8 + $urandom % 3);
        dw[2] = {32'($urandom), 20'($urandom), 12'h0};
        dw[3] = {4'($urandom), 16'h0, 12'($urandom), 32'($urandom)};
        case (kind)
            3: dw[0][0] = 1'b0;
            4: dw[0][2:1] = 2'b10;
            5: dw[0][3] = 1'b1;
            6: begin
                // Unsupported mode or bare mode with t2gpa
                if ($urandom % 2 == 0) begin
                    dw[1][63:60] = 4'd5;
                end else begin
                    dw[0][2]     = 1'b1;
                    dw[1][63:60] = 4'd0;
                end
            end
            7: begin
                dw[1][63:60] = 4'd8;
                cp.sv39x4 = 1'b0;
            end
            8: dw[2][$urandom % 12] = 1'b1;
            9: dw[3][44 + $urandom % 16] = 1'b1;
            default: ;
        endcase
        err_en = (kind == 10);
        err_beat = $urandom % (mode + 2);
        walk_beats = 0;
        a = {ppn, dw_offset(did, 1)};
        for (int b = 0; b < 4; b++) mem[a + 56'(8 * b)] = dw[b];
        ref_walk(did, mode, root, cp);
        u_mon.push_expect(exp_is_err, exp_cause, exp_upd);
        n0 = u_mon.seen_cnt;
        @(posedge clk_i);
        ddtc_access <= 1'b1;
        ddtc_hit    <= 1'b0;
        req_did     <= did;
        ddtp_mode   <= 4'(mode);
        ddtp_ppn    <= root;
        caps        <= cp;
        @(posedge clk_i);
        ddtc_access <= 1'b0;
        t = 0;
        act_bad = 1'b0;
        while (u_mon.seen_cnt == n0 && t < 2000) begin
            @(posedge clk_i);
            t++;
            // Walk stays active until its result pulse
            if (!act_bad && !active && !upd_valid && !walk_err && u_mon.seen_cnt == n0) begin
                $display("Fail at %0t ns: cdw_active_o low during the walk", $time);
                addr_errs++;
                act_bad = 1'b1;
            end
        end
        if (t >= 2000) begin
            $display("Timeout: walk for device %h gave no result", did);
            timeouts++;
        end
        if (exp_addr_q.size() != 0) begin
            $display("Fail at %0t ns: %0d expected reads missing", $time, exp_addr_q.size());
            addr_errs++;
        end
        repeat (2) @(posedge clk_i);
    endtask

    // A hit, or a miss with walking off, must leave the walker idle
    task automatic check_no_walk(input logic hit, input logic [3:0] mode);
        @(posedge clk_i);
        ddtc_access <= 1'b1;
        ddtc_hit    <= hit;
        ddtp_mode   <= mode;
        @(posedge clk_i);
        ddtc_access <= 1'b0;
        repeat (6) begin
            @(posedge clk_i);
            if (active || mem_req.ar_valid) begin
                $display("Fail at %0t ns: walk started without a miss in a walking mode",
                         $time);
                addr_errs++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha937f494));
        rst_ni      = 1'b0;
        ddtc_access = 1'b0;
        ddtc_hit    = 1'b0;
        req_did     = '0;
        ddtp_ppn    = '0;
        ddtp_mode   = '0;
        caps        = 4'b1110;
        err_en      = 1'b0;
        addr_errs   = 0;
        timeouts    = 0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < 99; i++) begin
            run_case(2 + i % 3, (i / 3) % 11);
        end
        check_no_walk(1'b1, 4'd3);
        check_no_walk(1'b0, 4'd0);
        check_no_walk(1'b0, 4'd1);
        $display("Errors: monitor %0d, address %0d, timeouts %0d",
                 u_mon.err_cnt, addr_errs, timeouts);
        if (u_mon.err_cnt == 0 && addr_errs == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/cdw_pkg.sv
verilog/ddt_walk_ptr.sv
verilog/dc_assembler.sv
verilog/ddt_entry_check.sv
verilog/cdw_ctrl.sv
verilog/iommu_cdw.sv
tb/cdw_monitor.sv
tb/tb_iommu_cdw.sv
